// File: verilog/ro_config.svh
`ifndef RO_CONFIG_SVH
`define RO_CONFIG_SVH

// 32-bit words in one 64-byte memory line
`define RO_LINE_WORDS 16

// tags in flight on the AR/R channels
`define RO_TAG_BITS 5

// thread slots, one per task being read
`define RO_THREAD_BITS 3

// largest element count a task may ask for
`define RO_MAX_ELEMS 64

`endif

// File: verilog/ro_pkg.sv
`include "ro_config.svh"

package ro_pkg;

   typedef logic [`RO_THREAD_BITS-1:0] thread_id_t;
   typedef logic [`RO_TAG_BITS-1:0]    tag_t;
   typedef logic [7:0]                 count_t;     // element counts and indices
   typedef logic [2:0]                 elem_size_t; // log2 of element bytes

   localparam elem_size_t ELEM_WORD = 3'd2;
   localparam elem_size_t ELEM_PAIR = 3'd3;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
      logic [3:0]  ttype;
   } task_t;

   typedef struct packed {
      task_t       task_info;
      logic [31:0] base;  // aligned to the element size
      elem_size_t  size;
      count_t      count;
   } ro_req_t;

   // one memory line seen as words or as aligned pairs
   typedef union packed {
      logic [`RO_LINE_WORDS-1:0][31:0]   words;
      logic [`RO_LINE_WORDS/2-1:0][63:0] pairs;
   } line_t;

   typedef struct packed {
      thread_id_t                thread;
      logic [`RO_LINE_WORDS-1:0] valid_words;
      elem_size_t                size;
      count_t                    elem_idx;    // element of the lowest valid word
   } mshr_entry_t;

   typedef struct packed {
      task_t       task_info;
      logic [63:0] data;
      count_t      elem_idx;
      logic        last;
   } ro_out_t;

endpackage

// File: verilog/ro_free_list.sv
`timescale 1ns/1ps

module ro_free_list #(
   parameter int LOG_DEPTH = 5
) (
   input  logic                 clk,
   input  logic                 rstn,

   input  logic                 push,
   input  logic [LOG_DEPTH-1:0] push_id,
   input  logic                 pop,

   output logic [LOG_DEPTH-1:0] next_id,
   output logic                 empty,
   output logic                 full
);

   localparam int DEPTH = 2**LOG_DEPTH;

   logic [LOG_DEPTH-1:0] ids [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   occ;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         // every identifier starts at home
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= LOG_DEPTH'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         occ    <= (LOG_DEPTH+1)'(DEPTH);
      end else begin
         if (push) begin
            ids[wr_ptr] <= push_id;
            wr_ptr      <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;
         endcase
      end
   end

   assign next_id = ids[rd_ptr];
   assign empty   = (occ == '0);
   assign full    = (occ == (LOG_DEPTH+1)'(DEPTH)); // nothing handed out

endmodule

// File: verilog/ro_read_request.sv
`timescale 1ns/1ps
`include "ro_config.svh"

module ro_read_request (
   input  logic                clk,
   input  logic                rstn,

   input  logic                req_valid,
   output logic                req_ready,
   input  ro_pkg::ro_req_t     req,

   input  ro_pkg::thread_id_t  thread_id,
   input  logic                thread_empty,
   output logic                thread_pop,

   input  ro_pkg::tag_t        tag_id,
   input  logic                tag_empty,
   output logic                tag_pop,

   output logic                arvalid,
   input  logic                arready,
   output logic [31:0]         araddr,
   output ro_pkg::tag_t        arid,

   output logic                mshr_wr,
   output ro_pkg::mshr_entry_t mshr_entry,

   output logic                ctx_wr,
   output ro_pkg::thread_id_t  ctx_thread,
   output ro_pkg::task_t       ctx_task,
   output ro_pkg::count_t      ctx_count
);

   import ro_pkg::*;

   localparam int IDX_BITS = $clog2(`RO_LINE_WORDS);
   localparam int OFF_BITS = IDX_BITS + 2;   // byte offset within a line

   logic                      busy;          // burst still has beats to issue
   logic [31:0]               addr;
   count_t                    n_words;       // words left in the burst
   elem_size_t                size;
   count_t                    elem_idx;
   thread_id_t                thread;

   logic [IDX_BITS-1:0]       word_off;
   logic [IDX_BITS:0]         line_room;
   logic [IDX_BITS:0]         beat_words;
   logic                      last_beat;
   logic [`RO_LINE_WORDS-1:0] mask;
   logic                      req_fire;
   logic                      ar_fire;

   always_comb begin
      word_off  = addr[OFF_BITS-1:2];
      line_room = (IDX_BITS+1)'(`RO_LINE_WORDS) - {1'b0, word_off};
      if (n_words <= count_t'(line_room)) begin
         last_beat  = 1'b1;
         beat_words = n_words[IDX_BITS:0];
      end else begin
         last_beat  = 1'b0;
         beat_words = line_room;
      end
      for (int i = 0; i < `RO_LINE_WORDS; i++) begin
         mask[i] = ((IDX_BITS+1)'(i) >= {1'b0, word_off}) &&
                   ((IDX_BITS+1)'(i) < {1'b0, word_off} + beat_words);
      end
   end

   assign arvalid   = busy & !tag_empty;    // no beat without a free tag
   assign ar_fire   = arvalid & arready;
   assign req_ready = !thread_empty & (!busy | (ar_fire & last_beat));
   assign req_fire  = req_valid & req_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else begin
         if (ar_fire) begin
            if (last_beat) begin
               busy <= 1'b0;
            end else begin
               addr    <= {addr[31:OFF_BITS] + 1'b1, {OFF_BITS{1'b0}}};
               n_words <= n_words - count_t'(beat_words);
               if (size == ELEM_PAIR) begin
                  elem_idx <= elem_idx + count_t'(beat_words >> 1);
               end else begin
                  elem_idx <= elem_idx + count_t'(beat_words);
               end
            end
         end
         // a new task may start on the cycle the old burst ends
         if (req_fire) begin
            busy     <= 1'b1;
            addr     <= req.base;
            size     <= req.size;
            thread   <= thread_id;
            elem_idx <= '0;
            if (req.size == ELEM_PAIR) begin
               n_words <= {req.count[6:0], 1'b0};
            end else begin
               n_words <= req.count;
            end
         end
      end
   end

   assign araddr  = addr;
   assign arid    = tag_id;
   assign tag_pop = ar_fire;

   assign mshr_wr                = ar_fire;
   assign mshr_entry.thread      = thread;
   assign mshr_entry.valid_words = mask;
   assign mshr_entry.size        = size;
   assign mshr_entry.elem_idx    = elem_idx;

   assign thread_pop = req_fire;
   assign ctx_wr     = req_fire;
   assign ctx_thread = thread_id;
   assign ctx_task   = req.task_info;
   assign ctx_count  = req.count;

endmodule

// File: verilog/ro_read_response.sv
`timescale 1ns/1ps
`include "ro_config.svh"

module ro_read_response (
   input  logic                clk,
   input  logic                rstn,

   input  logic                mshr_wr,
   input  ro_pkg::tag_t        mshr_tag,
   input  ro_pkg::mshr_entry_t mshr_entry,

   input  logic                rvalid,
   output logic                rready,
   input  ro_pkg::tag_t        rid,
   input  ro_pkg::line_t       rdata,

   output logic                tag_push,
   output ro_pkg::tag_t        tag_push_id,

   output ro_pkg::thread_id_t  cur_thread,
   input  ro_pkg::task_t       cur_task,
   input  logic                cur_last,

   output logic                out_fire,
   output logic                out_valid,
   input  logic                out_ready,
   output ro_pkg::ro_out_t     out
);

   import ro_pkg::*;

   localparam int IDX_BITS = $clog2(`RO_LINE_WORDS);

   mshr_entry_t               mshr [2**`RO_TAG_BITS];

   logic                      buf_valid;
   line_t                     buf_line;
   mshr_entry_t               buf_entry;   // mask and index advance as elements leave

   logic [IDX_BITS-1:0]       word_idx;
   logic                      is_pair;
   logic [`RO_LINE_WORDS-1:0] next_mask;
   logic [63:0]               out_data;
   logic                      r_fire;

   always_ff @(posedge clk) begin
      if (mshr_wr) begin
         mshr[mshr_tag] <= mshr_entry;
      end
   end

   // lowest valid word is the next element
   always_comb begin
      word_idx = '0;
      for (int i = `RO_LINE_WORDS-1; i >= 0; i--) begin
         if (buf_entry.valid_words[i]) begin
            word_idx = IDX_BITS'(i);
         end
      end
   end

   always_comb begin
      is_pair             = (buf_entry.size == ELEM_PAIR);
      next_mask           = buf_entry.valid_words;
      next_mask[word_idx] = 1'b0;
      if (is_pair) begin
         next_mask[{word_idx[IDX_BITS-1:1], 1'b1}] = 1'b0; // pairs are aligned
         out_data = buf_line.pairs[word_idx[IDX_BITS-1:1]];
      end else begin
         out_data = {32'b0, buf_line.words[word_idx]};
      end
   end

   assign out_valid = buf_valid;
   assign out_fire  = out_valid & out_ready;
   assign rready    = !buf_valid | (out_fire & (next_mask == '0));
   assign r_fire    = rvalid & rready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         buf_valid <= 1'b0;
      end else begin
         if (out_fire) begin
            buf_entry.valid_words <= next_mask;
            buf_entry.elem_idx    <= buf_entry.elem_idx + 1'b1;
            if (next_mask == '0) begin
               buf_valid <= 1'b0;
            end
         end
         if (r_fire) begin
            buf_valid <= 1'b1;
            buf_line  <= rdata;
            buf_entry <= mshr[rid];
         end
      end
   end

   // tag goes home as soon as its entry is copied out
   assign tag_push    = r_fire;
   assign tag_push_id = rid;

   assign cur_thread = buf_entry.thread;

   assign out.task_info = cur_task;
   assign out.data      = out_data;
   assign out.elem_idx  = buf_entry.elem_idx;
   assign out.last      = cur_last;

endmodule

// File: verilog/ro_thread_context.sv
`timescale 1ns/1ps
`include "ro_config.svh"

module ro_thread_context (
   input  logic               clk,
   input  logic               rstn,

   input  logic               ctx_wr,
   input  ro_pkg::thread_id_t ctx_thread,
   input  ro_pkg::task_t      ctx_task,
   input  ro_pkg::count_t     ctx_count,

   input  ro_pkg::thread_id_t cur_thread,
   input  logic               out_fire,
   output ro_pkg::task_t      cur_task,
   output logic               cur_last,

   output logic               thread_push,
   output ro_pkg::thread_id_t thread_push_id
);

   import ro_pkg::*;

   localparam int N_THREADS = 2**`RO_THREAD_BITS;
   localparam int CNT_BITS  = $clog2(`RO_MAX_ELEMS) + 1;

   task_t               tasks [N_THREADS];
   logic [CNT_BITS-1:0] remaining [N_THREADS];   // elements still to deliver

   always_ff @(posedge clk) begin
      if (ctx_wr) begin
         tasks[ctx_thread] <= ctx_task;
      end
   end

   // a freshly claimed slot never matches the thread being drained
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < N_THREADS; i++) begin
            remaining[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N_THREADS; i++) begin
            if (ctx_wr && (ctx_thread == thread_id_t'(i))) begin
               remaining[i] <= ctx_count[CNT_BITS-1:0];
            end else if (out_fire && (cur_thread == thread_id_t'(i))) begin
               remaining[i] <= remaining[i] - 1'b1;
            end
         end
      end
   end

   assign cur_task = tasks[cur_thread];
   assign cur_last = (remaining[cur_thread] == CNT_BITS'(1));

   assign thread_push    = out_fire & cur_last;   // slot freed with its last element
   assign thread_push_id = cur_thread;

endmodule

// File: verilog/ro_stage_top.sv
`timescale 1ns/1ps
`include "ro_config.svh"

module ro_stage_top (
   input  logic            clk,
   input  logic            rstn,

   input  logic            req_valid,
   output logic            req_ready,
   input  ro_pkg::ro_req_t req,

   output logic            arvalid,
   input  logic            arready,
   output logic [31:0]     araddr,
   output ro_pkg::tag_t    arid,

   input  logic            rvalid,
   output logic            rready,
   input  ro_pkg::tag_t    rid,
   input  ro_pkg::line_t   rdata,

   output logic            out_valid,
   input  logic            out_ready,
   output ro_pkg::ro_out_t out,

   output logic            idle
);

   import ro_pkg::*;

   tag_t        tag_next;
   logic        tag_empty;
   logic        tag_pop;
   logic        tag_push;
   tag_t        tag_push_id;

   thread_id_t  thread_next;
   logic        thread_empty;
   logic        thread_pop;
   logic        thread_push;
   thread_id_t  thread_push_id;

   logic        mshr_wr;
   mshr_entry_t mshr_entry;

   logic        ctx_wr;
   thread_id_t  ctx_thread;
   task_t       ctx_task;
   count_t      ctx_count;

   thread_id_t  cur_thread;
   task_t       cur_task;
   logic        cur_last;
   logic        out_fire;

   ro_free_list #(
      .LOG_DEPTH (`RO_TAG_BITS)
   ) u_tag_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (tag_push),
      .push_id (tag_push_id),
      .pop     (tag_pop),
      .next_id (tag_next),
      .empty   (tag_empty),
      .full    ()
   );

   ro_free_list #(
      .LOG_DEPTH (`RO_THREAD_BITS)
   ) u_thread_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (thread_push),
      .push_id (thread_push_id),
      .pop     (thread_pop),
      .next_id (thread_next),
      .empty   (thread_empty),
      .full    (idle)           // every slot home
   );

   ro_read_request u_read_request (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req          (req),
      .thread_id    (thread_next),
      .thread_empty (thread_empty),
      .thread_pop   (thread_pop),
      .tag_id       (tag_next),
      .tag_empty    (tag_empty),
      .tag_pop      (tag_pop),
      .arvalid      (arvalid),
      .arready      (arready),
      .araddr       (araddr),
      .arid         (arid),
      .mshr_wr      (mshr_wr),
      .mshr_entry   (mshr_entry),
      .ctx_wr       (ctx_wr),
      .ctx_thread   (ctx_thread),
      .ctx_task     (ctx_task),
      .ctx_count    (ctx_count)
   );

   ro_read_response u_read_response (
      .clk         (clk),
      .rstn        (rstn),
      .mshr_wr     (mshr_wr),
      .mshr_tag    (arid),
      .mshr_entry  (mshr_entry),
      .rvalid      (rvalid),
      .rready      (rready),
      .rid         (rid),
      .rdata       (rdata),
      .tag_push    (tag_push),
      .tag_push_id (tag_push_id),
      .cur_thread  (cur_thread),
      .cur_task    (cur_task),
      .cur_last    (cur_last),
      .out_fire    (out_fire),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out         (out)
   );

   ro_thread_context u_thread_context (
      .clk            (clk),
      .rstn           (rstn),
      .ctx_wr         (ctx_wr),
      .ctx_thread     (ctx_thread),
      .ctx_task       (ctx_task),
      .ctx_count      (ctx_count),
      .cur_thread     (cur_thread),
      .out_fire       (out_fire),
      .cur_task       (cur_task),
      .cur_last       (cur_last),
      .thread_push    (thread_push),
      .thread_push_id (thread_push_id)
   );

endmodule

// File: tb/tb_ro_stage.sv
`timescale 1ns/1ps
`include "ro_config.svh"

module tb_ro_stage;

   import ro_pkg::*;

   localparam int N_TASKS = 40;

   logic        clk;
   logic        rstn;
   logic        req_valid;
   logic        req_ready;
   ro_req_t     req;
   logic        arvalid;
   logic        arready;
   logic [31:0] araddr;
   tag_t        arid;
   logic        rvalid;
   logic        rready;
   tag_t        rid;
   line_t       rdata;
   logic        out_valid;
   logic        out_ready;
   ro_out_t     out;
   logic        idle;

   ro_req_t     reqs [N_TASKS];
   int          recv [N_TASKS];
   logic [63:0] seen [N_TASKS];
   int          exp_total = 0;
   int          total_out = 0;
   int          n_errors = 0;
   int          cyc = 0;

   // memory model state, one entry per outstanding AR
   tag_t        pend_tag [$];
   logic [31:0] pend_addr [$];
   int          pend_due [$];
   int          r_sel;
   int          k;
   line_t       ln;
   logic        r_free;

   int          issue_q [$];   // accepted tasks in order
   logic        ar_active = 1'b0;
   logic [31:0] ar_cursor;
   logic [31:0] ar_end;
   logic [31:0] nxt;
   int          id;
   logic [63:0] exp_d;
   logic        hold_pending = 1'b0;
   ro_out_t     held;

   ro_stage_top u_dut (
      .clk       (clk),
      .rstn      (rstn),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .arvalid   (arvalid),
      .arready   (arready),
      .araddr    (araddr),
      .arid      (arid),
      .rvalid    (rvalid),
      .rready    (rready),
      .rid       (rid),
      .rdata     (rdata),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out       (out),
      .idle      (idle)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] ref_word(input logic [31:0] a);
      return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
   endfunction

   function automatic logic [63:0] expected_data(input ro_req_t r, input count_t idx);
      logic [31:0] a;
      a = r.base + (32'(idx) << r.size);
      if (r.size == ELEM_PAIR) begin
         return {ref_word(a + 32'd4), ref_word(a)};   // lower address in the low half
      end else begin
         return {32'b0, ref_word(a)};
      end
   endfunction

   task automatic report_mismatch(input string name, input logic [159:0] exp_v,
                                  input logic [159:0] got_v);
      n_errors++;
      $display("CHECK FAILED t=%0t %s expected=%0h got=%0h", $time, name, exp_v, got_v);
   endtask

   task automatic report_problem(input string what);
      n_errors++;
      $display("error at t=%0t: %s", $time, what);
   endtask

   task automatic send_task(input int i);
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= reqs[i];
      do @(posedge clk); while (!req_ready);
      req_valid <= 1'b0;
   endtask

   // memory model with random delay and out-of-order returns
   always @(posedge clk) begin
      cyc = cyc + 1;
      arready   <= ($urandom_range(0, 3) != 0);
      out_ready <= ($urandom_range(0, 2) != 0);
      if (rstn) begin
         r_free = !rvalid;
         if (rvalid && rready) begin
            pend_tag.delete(r_sel);
            pend_addr.delete(r_sel);
            pend_due.delete(r_sel);
            r_free = 1'b1;
         end
         if (arvalid && arready) begin
            foreach (pend_tag[j]) begin
               assert (pend_tag[j] != arid) else report_problem("AR reused a tag in flight");
            end
            pend_tag.push_back(arid);
            pend_addr.push_back(araddr);
            pend_due.push_back(cyc + $urandom_range(1, 12));
         end
         if (r_free) begin
            rvalid <= 1'b0;
            if (pend_tag.size() > 0) begin
               k = $urandom_range(0, pend_tag.size() - 1);
               if (pend_due[k] <= cyc) begin
                  for (int w = 0; w < `RO_LINE_WORDS; w++) begin
                     ln.words[w] = ref_word({pend_addr[k][31:6], 6'b0} + 32'(w * 4));
                  end
                  rvalid <= 1'b1;
                  rid    <= pend_tag[k];
                  rdata  <= ln;
                  r_sel = k;
               end
            end
         end
      end
   end

   // AR beats must walk the task's byte range line by line
   always @(posedge clk) begin
      if (rstn) begin
         if (req_valid && req_ready) begin
            issue_q.push_back(int'(req.task_info.ts));
         end
         if (arvalid && arready) begin
            if (!ar_active) begin
               assert (issue_q.size() != 0)
                  else report_problem("AR beat without an accepted task");
               if (issue_q.size() != 0) begin
                  id = issue_q.pop_front();
                  ar_active = 1'b1;
                  ar_cursor = reqs[id].base;
                  ar_end    = reqs[id].base + (32'(reqs[id].count) << reqs[id].size);
               end
            end
            assert (araddr == ar_cursor) else report_mismatch("araddr", ar_cursor, araddr);
            nxt = {ar_cursor[31:6] + 26'd1, 6'b0};
            if (nxt >= ar_end) begin
               ar_active = 1'b0;   // last beat ends inside this line
            end else begin
               ar_cursor = nxt;
            end
         end
      end
   end

   // output compare against the reference
   always @(posedge clk) begin
      if (rstn) begin
         if (hold_pending) begin
            assert (out_valid) else report_problem("out_valid dropped while out_ready was low");
            assert (out == held) else report_mismatch("out", held, out);
         end
         if (out_valid && out_ready) begin
            id = int'(out.task_info.ts);
            assert (id >= 0 && id < N_TASKS)
               else report_problem("output carries an unknown task");
            if (id >= 0 && id < N_TASKS) begin
               exp_d = expected_data(reqs[id], out.elem_idx);
               assert (out.task_info == reqs[id].task_info)
                  else report_mismatch("out.task_info", reqs[id].task_info, out.task_info);
               assert (out.data == exp_d) else report_mismatch("out.data", exp_d, out.data);
               assert (out.elem_idx < reqs[id].count)
                  else report_mismatch("out.elem_idx", reqs[id].count, out.elem_idx);
               assert (!seen[id][out.elem_idx[5:0]])
                  else report_problem("element delivered twice");
               seen[id][out.elem_idx[5:0]] = 1'b1;
               recv[id]++;
               assert (out.last == (recv[id] == int'(reqs[id].count)))
                  else report_mismatch("out.last", recv[id] == int'(reqs[id].count), out.last);
            end
            total_out++;
         end
         hold_pending = out_valid && !out_ready;
         held         = out;
      end
   end

   initial begin
      repeat (N_TASKS * 200) @(posedge clk);
      $display("watchdog expired with %0d of %0d outputs seen", total_out, exp_total);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'h26e7c7b9));
      clk       = 1'b0;
      rstn      = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      arready   = 1'b0;
      rvalid    = 1'b0;
      rid       = '0;
      rdata     = '0;
      out_ready = 1'b0;
      for (int i = 0; i < N_TASKS; i++) begin
         reqs[i].task_info.ts     = i;
         reqs[i].task_info.locale = $urandom;
         reqs[i].task_info.ttype  = 4'($urandom);
         reqs[i].size  = ($urandom_range(0, 1) != 0) ? ELEM_PAIR : ELEM_WORD;
         reqs[i].count = count_t'($urandom_range(1, `RO_MAX_ELEMS));
         reqs[i].base  = $urandom & ((reqs[i].size == ELEM_PAIR) ? 32'h000f_fff8
                                                                : 32'h000f_fffc);
         recv[i] = 0;
         seen[i] = '0;
         exp_total += int'(reqs[i].count);
      end
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      @(posedge clk);
      assert (idle) else report_problem("idle low after reset");
      for (int i = 0; i < N_TASKS; i++) begin
         repeat ($urandom_range(0, 3)) @(posedge clk);
         send_task(i);
      end
      while (total_out < exp_total) @(posedge clk);
      repeat (3) @(posedge clk);
      assert (idle) else report_problem("idle low after all tasks finished");
      for (int i = 0; i < N_TASKS; i++) begin
         assert (recv[i] == int'(reqs[i].count))
            else report_mismatch("element count", reqs[i].count, recv[i]);
      end
      $display("tasks %0d, outputs %0d, errors %0d", N_TASKS, total_out, n_errors);
      if (n_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+verilog
verilog/ro_pkg.sv
verilog/ro_free_list.sv
verilog/ro_read_request.sv
verilog/ro_read_response.sv
verilog/ro_thread_context.sv
verilog/ro_stage_top.sv
tb/tb_ro_stage.sv

// File: Bender.yml
package:
  name: ro_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ro_pkg.sv
      - verilog/ro_free_list.sv
      - verilog/ro_read_request.sv
      - verilog/ro_read_response.sv
      - verilog/ro_thread_context.sv
      - verilog/ro_stage_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_ro_stage.sv
